// File: Makefile
VERILATOR ?= verilator
TOP       ?= tpu_tb
LOG       ?= sim.log
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

VFLAGS ?= --timing --assert --top-module $(TOP) -f $(FILELIST)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "TESTBENCH PASSED" $(LOG) || { echo "No pass message in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
common/tpu_pkg.sv
common/apb_pkg.sv
systolic/tpu_mac_array.sv
systolic/tpu_sequencer.sv
source/tpu_regs.sv
source/tpu_top.sv
dv/tpu_tb.sv

// File: common/apb_pkg.sv
package apb_pkg;

    localparam int ADDR_W = 8;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [ADDR_W-1:0] paddr;
        logic [31:0]       pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // Register map, byte addresses
    localparam logic [ADDR_W-1:0] CTRL_ADDR   = 8'h00;
    localparam logic [ADDR_W-1:0] STATUS_ADDR = 8'h04;
    localparam logic [ADDR_W-1:0] FEAT_BASE   = 8'h40;  // 16 words each
    localparam logic [ADDR_W-1:0] WGT_BASE    = 8'h80;
    localparam logic [ADDR_W-1:0] RES_BASE    = 8'hC0;

endpackage

// File: common/tpu_pkg.sv
package tpu_pkg;

    // Array geometry and datapath widths
    localparam int N          = 4;
    localparam int DATA_W     = 8;
    localparam int ACC_W      = 18;  // Four full-scale products plus sign
    localparam int RUN_CYCLES = 3 * N;

    typedef logic signed [DATA_W-1:0] elem_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    typedef elem_t [N-1:0]   vec_t;         // One array edge
    typedef elem_t [N*N-1:0] matrix_t;      // Row-major, (i,j) at i*N+j
    typedef acc_t  [N*N-1:0] acc_matrix_t;

    // Step counter for one run
    typedef logic [$clog2(RUN_CYCLES)-1:0] step_t;
    localparam step_t LAST_STEP = step_t'(RUN_CYCLES - 1);

    localparam acc_t ACT_MAX = acc_t'(127);

    // ReLU, then saturate to the largest positive element
    function automatic elem_t activate(acc_t x);
        if (x < 0) begin
            return '0;
        end
        if (x > ACT_MAX) begin
            return elem_t'(127);
        end
        return x[DATA_W-1:0];
    endfunction

endpackage

// File: dv/tpu_tb.sv
`timescale 1ns/1ps

module tpu_tb
    import tpu_pkg::*;
    import apb_pkg::*;
;

    localparam int CLK_PERIOD    = 8;
    localparam int NUM_RUNS      = 11;  // 8 random, busy errors, reuse, reset and idle checks
    localparam int XFERS_PER_RUN = 96;
    localparam int POLL_SLACK    = 40;
    localparam int TIMEOUT_NS    =
        NUM_RUNS * (XFERS_PER_RUN * 2 + RUN_CYCLES + POLL_SLACK) * CLK_PERIOD * 2;

    logic        clk;
    logic        rst;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic [31:0] lfsr;
    int          a_m[N*N];  // Feature model, row-major
    int          w_m[N*N];  // Weight model
    int          zero_seen;
    int          sat_seen;
    int          mid_seen;
    logic [31:0] rd;
    logic        err;

    tpu_top i_dut (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the test did not finish within %0d ns", TIMEOUT_NS);
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic int relu_sat(int x);
        if (x < 0) begin
            return 0;
        end
        return (x > 127) ? 127 : x;
    endfunction

    function automatic int expected_result(int i, int j);
        int sum;
        sum = 0;
        for (int k = 0; k < N; k++) begin
            sum += a_m[i*N + k] * w_m[k*N + j];
        end
        return relu_sat(sum);
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Setup then access cycle, called 1 ns after a rising edge
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        #1;
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        check("pready", 32'(apb_rsp.pready), 32'h1);
        @(posedge clk);
        #1;
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic slverr);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, data, unused, slverr);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic slverr);
        apb_xfer(1'b0, addr, 32'h0, data, slverr);
    endtask

    function automatic logic [7:0] word_addr(logic [7:0] base, int e);
        return base + 8'(e << 2);
    endfunction

    task automatic load_features();
        logic [31:0]       bits;
        logic signed [7:0] b;
        logic              e_err;
        for (int e = 0; e < N*N; e++) begin
            bits = take_bits(32);  // Upper bits are junk the DUT must ignore
            b = bits[7:0];
            a_m[e] = int'(b);
            apb_write(word_addr(FEAT_BASE, e), bits, e_err);
            check("pslverr on feature write", 32'(e_err), 32'h0);
        end
    endtask

    // Mix of full range, large positive and small weights to hit every activation region
    task automatic load_weights();
        logic [1:0]        sel;
        logic signed [7:0] b;
        logic signed [2:0] s;
        logic              e_err;
        for (int e = 0; e < N*N; e++) begin
            sel = 2'(take_bits(2));
            case (sel)
                2'd0: b = 8'(take_bits(8));
                2'd1: b = 8'(take_bits(7));
                default: begin
                    s = 3'(take_bits(3));
                    b = 8'(s);
                end
            endcase
            w_m[e] = int'(b);
            apb_write(word_addr(WGT_BASE, e), {24'h0, b}, e_err);
            check("pslverr on weight write", 32'(e_err), 32'h0);
        end
    endtask

    task automatic readback_operands(input logic feat_only);
        logic [31:0] data;
        logic        e_err;
        for (int e = 0; e < N*N; e++) begin
            apb_read(word_addr(FEAT_BASE, e), data, e_err);
            check($sformatf("feat[%0d]", e), data, 32'(a_m[e]));
            check("pslverr on feature read", 32'(e_err), 32'h0);
            if (!feat_only) begin
                apb_read(word_addr(WGT_BASE, e), data, e_err);
                check($sformatf("wgt[%0d]", e), data, 32'(w_m[e]));
                check("pslverr on weight read", 32'(e_err), 32'h0);
            end
        end
    endtask

    task automatic start_run();
        logic e_err;
        apb_write(CTRL_ADDR, 32'h1, e_err);
        check("pslverr on start", 32'(e_err), 32'h0);
    endtask

    // Poll until done_flag is set and busy is clear
    task automatic wait_done();
        logic [31:0] st;
        logic        e_err;
        do begin
            apb_read(STATUS_ADDR, st, e_err);
            check("pslverr on status poll", 32'(e_err), 32'h0);
        end while (st[1:0] != 2'b10);
    endtask

    task automatic check_results();
        logic [31:0] data;
        logic        e_err;
        int          exp;
        for (int e = 0; e < N*N; e++) begin
            exp = expected_result(e / N, e % N);
            apb_read(word_addr(RES_BASE, e), data, e_err);
            check($sformatf("result[%0d]", e), data, 32'(exp));
            check("pslverr on result read", 32'(e_err), 32'h0);
            if (exp == 0) zero_seen++;
            else if (exp == 127) sat_seen++;
            else mid_seen++;
        end
    endtask

    initial begin
        lfsr      = 32'h3427;
        zero_seen = 0;
        sat_seen  = 0;
        mid_seen  = 0;
        rst       = 1'b1;
        apb_req   = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // Reset state
        apb_read(STATUS_ADDR, rd, err);
        check("status after reset", rd, 32'h0);
        for (int e = 0; e < N*N; e++) begin
            apb_read(word_addr(RES_BASE, e), rd, err);
            check($sformatf("result[%0d] after reset", e), rd, 32'h0);
            check("pslverr after reset", 32'(err), 32'h0);
        end

        load_features();
        load_weights();
        readback_operands(1'b0);

        for (int r = 0; r < 8; r++) begin
            if (r > 0) begin
                load_features();
                load_weights();
            end
            start_run();
            wait_done();
            check_results();
        end

        // Rejected writes while idle
        apb_write(8'h10, 32'hFFFF_FFFF, err);
        check("pslverr unmapped write", 32'(err), 32'h1);
        apb_write(STATUS_ADDR, 32'h0, err);
        check("pslverr status write", 32'(err), 32'h1);
        apb_read(STATUS_ADDR, rd, err);
        check("status after rejected writes", rd, 32'h2);
        apb_write(RES_BASE, 32'h0000_0055 ^ 32'(expected_result(0, 0)), err);
        check("pslverr result write", 32'(err), 32'h1);
        apb_read(RES_BASE, rd, err);
        check("result[0] after rejected write", rd, 32'(expected_result(0, 0)));

        // Rejected writes during a run
        start_run();
        apb_write(WGT_BASE, 32'h0000_005A ^ 32'(w_m[0]), err);
        check("pslverr weight write while busy", 32'(err), 32'h1);
        apb_write(CTRL_ADDR, 32'h1, err);
        check("pslverr second start", 32'(err), 32'h1);
        apb_read(STATUS_ADDR, rd, err);
        check("status busy", rd, 32'h1);
        wait_done();
        apb_read(WGT_BASE, rd, err);
        check("wgt[0] after busy write", rd, 32'(w_m[0]));
        check_results();

        // Reuse with new weights only
        load_weights();
        start_run();
        wait_done();
        check_results();
        readback_operands(1'b1);

        check("zero results seen", 32'(zero_seen > 0), 32'h1);
        check("saturated results seen", 32'(sat_seen > 0), 32'h1);
        $display("Activation mix: %0d zero, %0d saturated, %0d linear",
                 zero_seen, sat_seen, mid_seen);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: source/tpu_regs.sv
`timescale 1ns/1ps

module tpu_regs
    import tpu_pkg::*;
    import apb_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp,
    output logic     start,
    output matrix_t  feat,
    output matrix_t  wgt,
    input  matrix_t  result,
    input  logic     done
);

    logic                        access;
    logic [$clog2(N*N)-1:0]      idx;
    logic [1:0]                  region;
    logic                        aligned;
    logic                        is_ctrl;
    logic                        is_status;
    logic                        is_feat;
    logic                        is_wgt;
    logic                        is_res;
    logic                        err;
    logic                        wr_ok;
    logic                        go;
    logic                        busy;
    logic                        done_flag;
    matrix_t                     res_q;
    logic [31:0]                 rdata;

    function automatic logic [31:0] sext(elem_t e);
        return {{(32 - DATA_W){e[DATA_W-1]}}, e};
    endfunction

    assign access  = apb_req.psel && apb_req.penable;
    assign idx     = apb_req.paddr[2 +: $clog2(N*N)];  // Word within a window
    assign region  = apb_req.paddr[ADDR_W-1 -: 2];
    assign aligned = (apb_req.paddr[1:0] == 2'b00);

    assign is_ctrl   = (apb_req.paddr == CTRL_ADDR);
    assign is_status = (apb_req.paddr == STATUS_ADDR);
    assign is_feat   = aligned && (region == FEAT_BASE[ADDR_W-1 -: 2]);
    assign is_wgt    = aligned && (region == WGT_BASE[ADDR_W-1 -: 2]);
    assign is_res    = aligned && (region == RES_BASE[ADDR_W-1 -: 2]);

    // Error decode for the access cycle
    always_comb begin
        err = 1'b0;
        if (access) begin
            if (!(is_ctrl || is_status || is_feat || is_wgt || is_res)) begin
                err = 1'b1;  // Unmapped
            end else if (apb_req.pwrite) begin
                if (is_status || is_res) begin
                    err = 1'b1;  // Read-only
                end else if ((is_feat || is_wgt) && busy) begin
                    err = 1'b1;  // Operands locked during a run
                end else if (is_ctrl && apb_req.pwdata[0] && busy) begin
                    err = 1'b1;
                end
            end
        end
    end

    assign wr_ok = access && apb_req.pwrite && !err;
    assign go    = wr_ok && is_ctrl && apb_req.pwdata[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            start     <= 1'b0;
            busy      <= 1'b0;
            done_flag <= 1'b0;
            feat      <= '0;
            wgt       <= '0;
            res_q     <= '0;
        end else begin
            start <= go;
            if (wr_ok && is_feat) begin
                feat[idx] <= apb_req.pwdata[DATA_W-1:0];
            end
            if (wr_ok && is_wgt) begin
                wgt[idx] <= apb_req.pwdata[DATA_W-1:0];
            end
            if (go) begin
                busy      <= 1'b1;
                done_flag <= 1'b0;
            end else if (done) begin
                busy      <= 1'b0;
                done_flag <= 1'b1;
                res_q     <= result;  // Capture activated results
            end
        end
    end

    // Read mux, CTRL reads as zero
    always_comb begin
        rdata = '0;
        if (is_status) begin
            rdata = {30'd0, done_flag, busy};
        end else if (is_feat) begin
            rdata = sext(feat[idx]);
        end else if (is_wgt) begin
            rdata = sext(wgt[idx]);
        end else if (is_res) begin
            rdata = sext(res_q[idx]);
        end
    end

    always_comb begin
        apb_rsp.prdata  = err ? '0 : rdata;
        apb_rsp.pready  = 1'b1;  // Zero wait states
        apb_rsp.pslverr = err;
    end

    a_penable_psel: assert property (@(posedge clk) disable iff (rst)
        apb_req.penable |-> apb_req.psel)
        else $error("penable seen without psel");

    // A new run is launched only from idle
    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        start |-> !$past(busy))
        else $error("start pulsed while busy");

endmodule

// File: source/tpu_top.sv
`timescale 1ns/1ps

module tpu_top
    import tpu_pkg::*;
    import apb_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    logic        start;
    logic        done;
    logic        clear;
    matrix_t     feat;
    matrix_t     wgt;
    matrix_t     result;
    vec_t        west;
    vec_t        north;
    acc_matrix_t acc;

    // Host side
    tpu_regs i_regs (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .start   (start),
        .feat    (feat),
        .wgt     (wgt),
        .result  (result),
        .done    (done)
    );

    tpu_sequencer i_seq (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .feat   (feat),
        .wgt    (wgt),
        .acc    (acc),
        .clear  (clear),
        .west   (west),
        .north  (north),
        .result (result),
        .done   (done)
    );

    tpu_mac_array i_array (
        .clk   (clk),
        .rst   (rst),
        .clear (clear),
        .west  (west),
        .north (north),
        .acc   (acc)
    );

endmodule

// File: systolic/tpu_mac_array.sv
`timescale 1ns/1ps

module tpu_mac_array
    import tpu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        clear,
    input  vec_t        west,
    input  vec_t        north,
    output acc_matrix_t acc
);

    matrix_t     west_in;   // Operand seen by each cell this cycle
    matrix_t     north_in;
    matrix_t     west_q;    // Forwarded east
    matrix_t     north_q;   // Forwarded south
    acc_matrix_t acc_q;

    // Cell inputs come from the array edge or the neighbour's register
    for (genvar i = 0; i < N; i++) begin : g_row
        for (genvar j = 0; j < N; j++) begin : g_col
            if (j == 0) begin : g_west_edge
                assign west_in[i*N + j] = west[i];
            end else begin : g_west_fwd
                assign west_in[i*N + j] = west_q[i*N + j - 1];
            end
            if (i == 0) begin : g_north_edge
                assign north_in[i*N + j] = north[j];
            end else begin : g_north_fwd
                assign north_in[i*N + j] = north_q[(i-1)*N + j];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            acc_q   <= '0;
            west_q  <= '0;
            north_q <= '0;
        end else begin
            for (int e = 0; e < N*N; e++) begin
                acc_q[e] <= acc_q[e] + acc_t'(west_in[e]) * acc_t'(north_in[e]);
            end
            west_q  <= west_in;
            north_q <= north_in;
        end
    end

    assign acc = acc_q;

endmodule

// File: systolic/tpu_sequencer.sv
`timescale 1ns/1ps

module tpu_sequencer
    import tpu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  matrix_t     feat,
    input  matrix_t     wgt,
    input  acc_matrix_t acc,
    output logic        clear,
    output vec_t        west,
    output vec_t        north,
    output matrix_t     result,
    output logic        done
);

    logic  running;
    step_t step;
    logic  last;

    assign last = running && (step == LAST_STEP);

    // Steps 0..RUN_CYCLES-1 follow the start cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            step    <= '0;
        end else if (start) begin
            running <= 1'b1;
            step    <= '0;
        end else if (last) begin
            running <= 1'b0;
        end else if (running) begin
            step <= step + step_t'(1);
        end
    end

    // Accumulators are zeroed on the edge that launches the run
    assign clear = start;

    // Skewed operand injection
    // Row i enters west lane i delayed by i steps, column j enters north lane j by j steps
    always_comb begin
        int k;
        west  = '0;
        north = '0;
        for (int i = 0; i < N; i++) begin
            k = int'(step) - i;
            if (running && k >= 0 && k < N) begin
                west[i]  = feat[i*N + k];  // A[i][t-i]
                north[i] = wgt[k*N + i];   // W[t-i][i]
            end
        end
    end

    // The last wavefront settles before the final step
    always_comb begin
        for (int e = 0; e < N*N; e++) begin
            result[e] = activate(acc[e]);
        end
    end

    assign done = last;

    a_done_latency: assert property (@(posedge clk) disable iff (rst)
        start |-> ##RUN_CYCLES done)
        else $error("done missing %0d cycles after start", RUN_CYCLES);

    a_done_cause: assert property (@(posedge clk) disable iff (rst)
        done |-> $past(start, RUN_CYCLES))
        else $error("done without a matching start");

endmodule
